// File: build.f
rtl/adc_stream_pkg.sv
rtl/sample_stamp.sv
rtl/channel_decimator.sv
rtl/stream_packer.sv
rtl/adc_stream_top.sv
sim/tb_clock_gen.sv
sim/tb_adc_stream.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the testbench twice, full set counter limit and limit 50
cd "$(dirname "$0")" || exit 1

run_config() {
    verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_adc_stream \
        -GVALID_COUNT_MAX="$2" -Mdir "obj_$1" -o sim_tb || return 1
    out=$("./obj_$1/sim_tb")
    echo "$out"
    echo "$out" | grep -q "NO ERRORS"
}

run_config full 8000 && run_config sat 50 && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: sim/tb_adc_stream.sv
`timescale 1ns/1ps

// Random stimulus for the sample path with a cycle-level reference model
// Every strobe is predicted to leave as a word 3 cycles later
module tb_adc_stream
    import adc_stream_pkg::*;
#(
    parameter int NUM_CH          = 16,
    parameter int VALID_COUNT_MAX = 8000    // Lowered to 50 for the saturation run
);

    localparam int CLK_PERIOD_NS = 4;
    localparam int RST_CYCLES    = 5;
    localparam int NUM_SEGS      = 24;      // Stimulus segments with their own config
    localparam int GAP_CYCLES    = 5;       // Idle cycles before any config change
    localparam int SEG_MIN       = 30;
    localparam int SEG_MAX       = 90;
    localparam int MARGIN        = 200;
    localparam int WATCHDOG_CYCLES =
        NUM_SEGS * (GAP_CYCLES + 1 + SEG_MAX) + 2 * RST_CYCLES + GAP_CYCLES + MARGIN;

    // One predicted output word
    typedef struct packed {
        int           due;                  // Cycle index where it must show up
        stream_word_t data;
        logic         first;
        logic         last;
    } exp_word_t;

    logic         clk;
    logic         rst;
    logic         rst_req;
    logic         sample_valid;
    sample_t      sample_data [NUM_CH];
    logic         ena;
    ch_sel_t      ch0_sel;
    ch_sel_t      ch1_sel;
    rate_div_t    rate_div;
    pkt_len_t     num_samples;
    block_t       block;
    logic         word_valid;
    logic         word_first;
    logic         word_last;
    stream_word_t word_data;
    count_t       valid_count;

    // Model state
    int        cyc;                         // Cycles since reset release and thus the timestamp
    count_t    exp_count;
    int        phase;
    bit        pkt_active;
    int        pkt_len;
    int        pkt_cnt;
    exp_word_t exp_q[$];

    int  word_errs;
    int  count_errs;
    int  other_errs;
    logic rst_q;                            // Reset as seen by the last rising edge

    tb_clock_gen #(.RST_CYCLES(RST_CYCLES)) clk_gen (
        .rst_req (rst_req),
        .clk     (clk),
        .rst     (rst)
    );

    adc_stream_top #(
        .NUM_CH          (NUM_CH),
        .VALID_COUNT_MAX (VALID_COUNT_MAX)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .ena          (ena),
        .ch0_sel      (ch0_sel),
        .ch1_sel      (ch1_sel),
        .rate_div     (rate_div),
        .num_samples  (num_samples),
        .block        (block),
        .word_valid   (word_valid),
        .word_first   (word_first),
        .word_last    (word_last),
        .word_data    (word_data),
        .valid_count  (valid_count)
    );

    task automatic check_word(input stream_word_t got, input logic got_first,
                              input logic got_last, input stream_word_t exp,
                              input logic exp_first, input logic exp_last);
        if (got !== exp || got_first !== exp_first || got_last !== exp_last) begin
            $display("Fail %0t: word %h first %b last %b, expected %h first %b last %b",
                     $time, got, got_first, got_last, exp, exp_first, exp_last);
            word_errs++;
        end
    endtask

    task automatic check_count(input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("Fail %0t: valid_count %0d, expected %0d", $time, got, exp);
            count_errs++;
        end
    endtask

    // Outputs as registered by the last edge
    task automatic score_outputs();
        check_count(valid_count, exp_count);
        while (exp_q.size() > 0 && exp_q[0].due < cyc) begin
            $display("Expected word %h never appeared, noticed at %0t", exp_q[0].data, $time);
            other_errs++;
            exp_q.delete(0);
        end
        if (word_valid === 1'b1) begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                check_word(word_data, word_first, word_last,
                           exp_q[0].data, exp_q[0].first, exp_q[0].last);
                exp_q.delete(0);
            end else begin
                $display("Unexpected word %h came out at %0t", word_data, $time);
                other_errs++;
            end
        end else if (word_valid !== 1'b0) begin
            $display("word_valid is unknown at %0t", $time);
            other_errs++;
        end
    endtask

    // Predicts stamp, decimation and framing for the set driven this cycle
    task automatic model_strobe();
        ts_t       ts;
        bit        picked;
        exp_word_t ent;
        ts = ts_t'(cyc);                    // Timestamp of the strobe cycle
        if (exp_count < count_t'(VALID_COUNT_MAX)) begin
            exp_count = exp_count + 1;
        end
        picked = 1'b0;
        if (ena) begin
            picked = (phase == 0);
            phase  = (phase == int'(rate_div)) ? 0 : phase + 1;
        end
        if (!picked) begin
            return;
        end
        ent.first = 1'b0;
        if (!pkt_active) begin
            if (block != '0) begin
                return;                     // Set is lost while idle and blocked
            end
            pkt_active = 1'b1;
            pkt_len    = (num_samples == '0) ? 1 : int'(num_samples);
            pkt_cnt    = 0;
            ent.first  = 1'b1;
        end
        pkt_cnt++;
        ent.last = (pkt_cnt == pkt_len);
        if (ent.last) begin
            pkt_active = 1'b0;
        end
        ent.due  = cyc + 3;
        ent.data = {ts[TS_WORD_W-1:0], sample_data[ch1_sel], sample_data[ch0_sel]};
        exp_q.push_back(ent);
    endtask

    // One clock cycle that starts and ends 1 ns after a rising edge
    task automatic run_cycle(input bit strobe);
        score_outputs();
        sample_valid = strobe;
        for (int i = 0; i < NUM_CH; i++) begin
            sample_data[i] = sample_t'($urandom);
        end
        if (!ena) begin
            phase = 0;                      // Decimator phase rests while disabled
        end
        if (strobe) begin
            model_strobe();
        end
        @(posedge clk);
        #1;
        cyc++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) run_cycle(1'b0);
    endtask

    function automatic block_t random_block();
        if ($urandom % 4 == 0) begin
            return block_t'(1 + $urandom % 3);
        end
        return '0;
    endfunction

    // Static registers change only with ena low and the pipeline empty
    task automatic reconfigure();
        ena = 1'b0;
        run_cycle(1'b0);
        ch0_sel     = ch_sel_t'($urandom % NUM_CH);
        ch1_sel     = ch_sel_t'($urandom % NUM_CH);
        rate_div    = rate_div_t'($urandom % 6);
        num_samples = pkt_len_t'($urandom % 7);     // 0 acts as one word
        ena         = ($urandom % 5 != 0);
        block       = random_block();
    endtask

    task automatic restart();
        rst_req      = 1'b1;
        sample_valid = 1'b0;
        @(negedge rst);
        rst_req    = 1'b0;
        exp_q.delete();                     // Sets in flight are flushed by the reset
        exp_count  = count_t'(1);
        phase      = 0;
        pkt_active = 1'b0;
        pkt_cnt    = 0;
        cyc        = 0;                     // Timestamp starts over
    endtask

    always @(posedge clk) begin
        rst_q <= rst;
    end

    // word_valid must be low once a rising edge has seen the reset
    always @(negedge clk) begin
        if (rst && rst_q && word_valid !== 1'b0) begin
            $display("word_valid was not low during reset at %0t", $time);
            other_errs++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int density;
        int seg_len;
        bit restarted;
        void'($urandom(32'h723a));
        rst_req      = 1'b0;
        sample_valid = 1'b0;
        for (int i = 0; i < NUM_CH; i++) begin
            sample_data[i] = '0;
        end
        ena         = 1'b0;
        ch0_sel     = '0;
        ch1_sel     = '0;
        rate_div    = '0;
        num_samples = pkt_len_t'(1);
        block       = '0;
        word_errs   = 0;
        count_errs  = 0;
        other_errs  = 0;
        exp_count   = count_t'(1);
        phase       = 0;
        pkt_active  = 1'b0;
        pkt_len     = 1;
        pkt_cnt     = 0;
        cyc         = 0;
        restarted   = 1'b0;

        @(negedge rst);
        for (int seg = 0; seg < NUM_SEGS; seg++) begin
            idle_cycles(GAP_CYCLES);
            if (seg == 0 || $urandom % 3 != 0) begin
                reconfigure();
            end else begin
                block = random_block();     // Open packet must still finish with ena kept
            end
            density = 20 + $urandom % 81;   // 100 gives back-to-back strobes
            seg_len = SEG_MIN + $urandom % (SEG_MAX - SEG_MIN + 1);
            repeat (seg_len) begin
                if (!restarted && seg >= NUM_SEGS / 2 && exp_q.size() > 0
                    && exp_q[$].due > cyc) begin
                    restart();              // Mid-run reset with words still in the pipeline
                    restarted = 1'b1;
                end
                run_cycle($urandom % 100 < density);
            end
        end
        idle_cycles(GAP_CYCLES);            // Drain the pipeline
        if (!restarted) begin
            $display("The mid-run reset was never applied");
            other_errs++;
        end
        if (exp_q.size() > 0) begin
            $display("%0d expected words were still missing at the end", exp_q.size());
            other_errs += exp_q.size();
        end

        $display("Summary: %0d word errors, %0d count errors, %0d protocol errors",
                 word_errs, count_errs, other_errs);
        if (word_errs + count_errs + other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

// Clock and reset source for the testbench
// 4 ns clock, reset held for RST_CYCLES rising edges at start and on request
module tb_clock_gen #(
    parameter int RST_CYCLES = 5
)(
    input  logic rst_req,                   // Rising edge starts another reset
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 250 MHz
    end

    initial begin
        rst = 1'b1;
        forever begin
            repeat (RST_CYCLES) @(posedge clk);
            #1;
            rst = 1'b0;                     // Released 1 ns after the edge, like stimulus
            @(posedge rst_req);
            rst = 1'b1;
        end
    end

endmodule

// File: rtl/adc_stream_top.sv
`timescale 1ns/1ps

// Sample path from conversion results to the streaming FIFO
// stamp -> decimate -> pack, one register per stage, 3 cycles end to end
module adc_stream_top
    import adc_stream_pkg::*;
#(
    parameter int NUM_CH          = 16,     // At most 2**CH_SEL_W channels
    parameter int VALID_COUNT_MAX = 8000    // Saturation point of valid_count
)(
    input  logic         clk,
    input  logic         rst,

    // Conversion results
    input  logic         sample_valid,
    input  sample_t      sample_data [NUM_CH],

    // Stream control registers
    input  logic         ena,
    input  ch_sel_t      ch0_sel,
    input  ch_sel_t      ch1_sel,
    input  rate_div_t    rate_div,
    input  pkt_len_t     num_samples,
    input  block_t       block,             // External inhibit

    // Toward the stream FIFO
    output logic         word_valid,
    output logic         word_first,
    output logic         word_last,
    output stream_word_t word_data,

    output count_t       valid_count        // Status register
);

    logic    stamp_valid;
    sample_t stamp_data [NUM_CH];
    ts_t     stamp_ts;

    logic    pick_valid;
    sample_t pick_ch0;
    sample_t pick_ch1;
    ts_t     pick_ts;

    sample_stamp #(
        .NUM_CH          (NUM_CH),
        .VALID_COUNT_MAX (VALID_COUNT_MAX)
    ) u_stamp (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .stamp_valid  (stamp_valid),
        .stamp_data   (stamp_data),
        .stamp_ts     (stamp_ts),
        .valid_count  (valid_count)
    );

    channel_decimator #(
        .NUM_CH (NUM_CH)
    ) u_decim (
        .clk         (clk),
        .rst         (rst),
        .ena         (ena),
        .ch0_sel     (ch0_sel),
        .ch1_sel     (ch1_sel),
        .rate_div    (rate_div),
        .stamp_valid (stamp_valid),
        .stamp_data  (stamp_data),
        .stamp_ts    (stamp_ts),
        .pick_valid  (pick_valid),
        .pick_ch0    (pick_ch0),
        .pick_ch1    (pick_ch1),
        .pick_ts     (pick_ts)
    );

    stream_packer u_pack (
        .clk         (clk),
        .rst         (rst),
        .block       (block),
        .num_samples (num_samples),
        .pick_valid  (pick_valid),
        .pick_ch0    (pick_ch0),
        .pick_ch1    (pick_ch1),
        .pick_ts     (pick_ts),
        .word_valid  (word_valid),
        .word_first  (word_first),
        .word_last   (word_last),
        .word_data   (word_data)
    );

endmodule

// File: rtl/stream_packer.sv
`timescale 1ns/1ps

// Third pipeline stage
// Packs timestamp low bits and the two samples into one 64-bit word per
// picked set and frames the words into packets of num_samples words
module stream_packer
    import adc_stream_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  block_t       block,             // Any bit set inhibits new packets
    input  pkt_len_t     num_samples,       // Words per packet, 0 acts as 1

    input  logic         pick_valid,
    input  sample_t      pick_ch0,
    input  sample_t      pick_ch1,
    input  ts_t          pick_ts,

    output logic         word_valid,
    output logic         word_first,
    output logic         word_last,
    output stream_word_t word_data
);

    logic         active;                   // Inside a packet
    pkt_len_t     pkt_len;                  // Length latched at packet start
    pkt_len_t     word_cnt;                 // Words already sent in this packet

    logic         start;
    logic         take;
    logic         is_last;
    pkt_len_t     start_len;
    pkt_len_t     len_now;
    pkt_len_t     cnt_now;
    pkt_len_t     cnt_next;
    stream_word_t word_nxt;

    // Packet framing decisions
    always_comb begin
        start_len = (num_samples == '0) ? pkt_len_t'(1) : num_samples;

        // Idle and unblocked, a picked set opens a packet
        start = pick_valid && !active && (block == '0);
        // Blocked sets while idle fall through here and are dropped
        take  = start || (pick_valid && active);

        len_now  = active ? pkt_len : start_len;
        cnt_now  = active ? word_cnt : '0;
        cnt_next = cnt_now + 1'b1;
        is_last  = (cnt_next == len_now);   // Also true for a one-word packet
    end

    // Word assembly
    always_comb begin
        word_nxt = '0;
        word_nxt[WORD_TS_LSB  +: TS_WORD_W] = pick_ts[TS_WORD_W-1:0];
        word_nxt[WORD_CH1_LSB +: SAMPLE_W]  = pick_ch1;
        word_nxt[WORD_CH0_LSB +: SAMPLE_W]  = pick_ch0;
    end

    // Packet state
    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            pkt_len  <= pkt_len_t'(1);
            word_cnt <= '0;
        end else if (take) begin
            if (start) begin
                pkt_len <= start_len;       // Length frozen for the whole packet
            end
            active   <= !is_last;
            word_cnt <= is_last ? '0 : cnt_next;
        end
    end

    // Output strobes and flags
    always_ff @(posedge clk) begin
        if (rst) begin
            word_valid <= 1'b0;
            word_first <= 1'b0;
            word_last  <= 1'b0;
        end else begin
            word_valid <= take;
            word_first <= start;
            word_last  <= take && is_last;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            word_data <= word_nxt;
        end
    end

    // Flags only ever qualify a valid word
    a_flags_valid: assert property (
        @(posedge clk) disable iff (rst)
        (word_first || word_last) |-> word_valid
    ) else $error("packet flag without word_valid");

endmodule

// File: rtl/channel_decimator.sv
`timescale 1ns/1ps

// Second pipeline stage
// Selects two channels out of each stamped set and keeps one set out of
// every rate_div+1 while streaming is enabled
module channel_decimator
    import adc_stream_pkg::*;
#(
    parameter int NUM_CH = 16
)(
    input  logic      clk,
    input  logic      rst,

    input  logic      ena,                  // Stream enable from the register map
    input  ch_sel_t   ch0_sel,
    input  ch_sel_t   ch1_sel,
    input  rate_div_t rate_div,             // Keep every (rate_div+1)th set

    input  logic      stamp_valid,
    input  sample_t   stamp_data [NUM_CH],
    input  ts_t       stamp_ts,

    output logic      pick_valid,
    output sample_t   pick_ch0,
    output sample_t   pick_ch1,
    output ts_t       pick_ts
);

    rate_div_t phase;                       // Position inside the decimation period
    sample_t   sel_ch0;
    sample_t   sel_ch1;
    logic      keep;

    // Channel multiplexers
    // Selector values beyond NUM_CH give zero
    always_comb begin
        sel_ch0 = '0;
        sel_ch1 = '0;
        for (int i = 0; i < NUM_CH; i++) begin
            if (ch0_sel == ch_sel_t'(i)) begin
                sel_ch0 = stamp_data[i];
            end
            if (ch1_sel == ch_sel_t'(i)) begin
                sel_ch1 = stamp_data[i];
            end
        end
    end

    assign keep = stamp_valid && ena && (phase == '0);  // First set of each period

    // Phase counter, held at 0 while disabled so the first set after enable is kept
    always_ff @(posedge clk) begin
        if (rst || !ena) begin
            phase <= '0;
        end else if (stamp_valid) begin
            if (phase == rate_div) begin
                phase <= '0;        // Wrap
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pick_valid <= 1'b0;
        end else begin
            pick_valid <= keep;
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            pick_ch0 <= sel_ch0;
            pick_ch1 <= sel_ch1;
            pick_ts  <= stamp_ts;   // Timestamp travels with the pair
        end
    end

    // Register map must only select existing channels while streaming
    a_sel_range: assert property (
        @(posedge clk) disable iff (rst)
        ena |-> (int'(ch0_sel) < NUM_CH) && (int'(ch1_sel) < NUM_CH)
    ) else $error("channel selector out of range while enabled");

endmodule

// File: rtl/sample_stamp.sv
`timescale 1ns/1ps

// First pipeline stage
// Registers every incoming sample set together with the timestamp of its
// strobe cycle and keeps a saturating count of accepted sets
module sample_stamp
    import adc_stream_pkg::*;
#(
    parameter int NUM_CH          = 16,
    parameter int VALID_COUNT_MAX = 8000
)(
    input  logic    clk,
    input  logic    rst,

    input  logic    sample_valid,           // One-cycle strobe per conversion set
    input  sample_t sample_data [NUM_CH],

    output logic    stamp_valid,
    output sample_t stamp_data [NUM_CH],
    output ts_t     stamp_ts,               // ts value in the strobe cycle
    output count_t  valid_count
);

    localparam count_t COUNT_MAX = count_t'(VALID_COUNT_MAX);

    ts_t ts_count;                          // Free-running time base

    // Timestamp, 0 in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            ts_count <= '0;
        end else begin
            ts_count <= ts_count + 1'b1;
        end
    end

    // Strobe is delayed by one cycle alongside the data
    always_ff @(posedge clk) begin
        if (rst) begin
            stamp_valid <= 1'b0;
        end else begin
            stamp_valid <= sample_valid;
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            stamp_data <= sample_data;
            stamp_ts   <= ts_count;     // Time of this strobe, not of the output
        end
    end

    // Set counter starts at 1 and sticks at the limit
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_count <= count_t'(1);
        end else if (sample_valid) begin
            if (valid_count < COUNT_MAX) begin
                valid_count <= valid_count + 1'b1;
            end else begin
                valid_count <= COUNT_MAX;   // Saturate
            end
        end
    end

    // Counter stays within its limit over any number of strobes
    a_count_limit: assert property (
        @(posedge clk) disable iff (rst)
        valid_count <= COUNT_MAX
    ) else $error("valid_count above VALID_COUNT_MAX");

endmodule

// File: rtl/adc_stream_pkg.sv
package adc_stream_pkg;

    // ADC result, two's complement straight from the converter
    localparam int SAMPLE_W = 18;
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Free-running timestamp
    localparam int TS_W = 64;
    typedef logic [TS_W-1:0] ts_t;
    localparam int TS_WORD_W = 28;      // Timestamp bits that fit next to two samples

    // Stream control fields, widths as in the register map
    localparam int CH_SEL_W = 4;
    typedef logic [CH_SEL_W-1:0] ch_sel_t;

    localparam int RATE_DIV_W = 7;
    typedef logic [RATE_DIV_W-1:0] rate_div_t;

    localparam int NUM_SAMPLES_W = 16;
    typedef logic [NUM_SAMPLES_W-1:0] pkt_len_t;

    localparam int BLOCK_W = 2;         // One bit per external inhibit input
    typedef logic [BLOCK_W-1:0] block_t;

    // Stream word toward the FIFO
    localparam int WORD_W = 64;
    typedef logic [WORD_W-1:0] stream_word_t;

    // Word layout, LSB of each field
    // ts[27:0] in 63..36, ch1 in 35..18, ch0 in 17..0
    localparam int WORD_CH0_LSB = 0;
    localparam int WORD_CH1_LSB = WORD_CH0_LSB + SAMPLE_W;
    localparam int WORD_TS_LSB  = WORD_CH1_LSB + SAMPLE_W;

    // Accepted-set counter
    localparam int VALID_COUNT_W = 32;
    typedef logic [VALID_COUNT_W-1:0] count_t;

endpackage
